//--- hw/vlsu_pkg.sv
////////////////////////////////////////////////////////////
// vector LSU shared definitions
// word geometry, exception codes, modes and beat structs
////////////////////////////////////////////////////////////

package vlsu_pkg;

    // memory word geometry
    localparam int unsigned VMEM_W = 32;
    localparam int unsigned VMEM_B = VMEM_W / 8;
    localparam int unsigned OFF_W  = $clog2(VMEM_B);
    localparam int unsigned ID_W   = 3;

    // access fault codes reported on bus errors
    localparam logic [5:0] EXC_LOAD_FAULT  = 6'd5;
    localparam logic [5:0] EXC_STORE_FAULT = 6'd7;

    typedef enum logic [1:0] {
        VSEW_8  = 2'd0,
        VSEW_16 = 2'd1,
        VSEW_32 = 2'd2
    } vsew_e;

    typedef enum logic [1:0] {
        LSU_UNITSTRIDE = 2'd0,
        LSU_STRIDED    = 2'd1,
        LSU_INDEXED    = 2'd2
    } lsu_stride_e;

    typedef struct packed {
        logic        store;
        logic        masked;
        lsu_stride_e stride;
        vsew_e       eew;
    } lsu_mode_t;

    // control of one beat as issued by the pipe
    typedef struct packed {
        logic             first_cycle;
        logic             last_cycle;
        logic [ID_W-1:0]  id;
        lsu_mode_t        mode;
        logic [OFF_W-1:0] vl_part;
        logic             vl_part_0;
        logic [31:0]      xval;
        logic [4:0]       res_vaddr;
        logic             res_store;
    } lsu_ctrl_t;

    // state kept per in-flight request
    typedef struct packed {
        logic [OFF_W-1:0]  off;
        logic [VMEM_B-1:0] mask;
        logic              first_cycle;
        logic              last_cycle;
        logic [ID_W-1:0]   id;
        lsu_mode_t         mode;
        logic [OFF_W-1:0]  vl_part;
        logic              vl_part_0;
        logic [4:0]        res_vaddr;
        logic              res_store;
    } lsu_entry_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [31:0]       addr;
        logic              we;
        logic [VMEM_B-1:0] be;
        logic [VMEM_W-1:0] wdata;
        logic              last;
    } mem_req_t;

    typedef struct packed {
        logic [VMEM_W-1:0] rdata;
        logic              err;
    } mem_result_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic            exc;
        logic [5:0]      exccode;
    } trans_cpl_t;

endpackage

//--- hw/vlsu_req_stage.sv
////////////////////////////////////////////////////////////
// vector LSU request stage
// address generation, store data and byte enables, request register
////////////////////////////////////////////////////////////

module vlsu_req_stage #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                              clk_i,
    input  logic                              async_rst_ni,

    input  logic                              pipe_in_valid_i,
    output logic                              pipe_in_ready_o,
    input  vlsu_pkg::lsu_ctrl_t               pipe_in_ctrl_i,
    input  logic [31:0]                       pipe_in_op1_i,
    input  logic [vlsu_pkg::VMEM_W-1:0]       pipe_in_op2_i,
    input  logic [vlsu_pkg::VMEM_B-1:0]       pipe_in_mask_i,

    output logic                              mem_req_valid_o,
    input  logic                              mem_req_ready_i,
    output vlsu_pkg::mem_req_t                mem_req_o,

    input  logic                              queue_ready_i,
    output logic                              enq_valid_o,
    output vlsu_pkg::lsu_entry_t              enq_entry_o,

    output logic                              pending_load_o,
    output logic                              pending_store_o
);

    import vlsu_pkg::*;

    if (QUEUE_DEPTH < 2 || (QUEUE_DEPTH & (QUEUE_DEPTH - 1)) != 0) begin : g_depth_check
        $error("QUEUE_DEPTH must be a power of two of at least 2");
    end

    logic              req_valid_q;
    logic              req_ready;
    logic              req_accept;
    lsu_ctrl_t         ctrl_q;
    logic [31:0]       addr_q, addr_d;
    logic [VMEM_W-1:0] wdata_q, wdata_d;
    logic [VMEM_B-1:0] be_q, be_d;
    logic [VMEM_B-1:0] mask_q;
    logic [31:0]       index_ext;
    logic [VMEM_B-1:0] unit_vl_mask;
    logic              stri_bit;
    logic [OFF_W-1:0]  addr_off;

    ////////////////////////////////////////////////////////////
    // address generation

    // index zero-extended to the element width
    always_comb begin
        unique case (pipe_in_ctrl_i.mode.eew)
            VSEW_8:  index_ext = {24'b0, pipe_in_op1_i[7:0]};
            VSEW_16: index_ext = {16'b0, pipe_in_op1_i[15:0]};
            default: index_ext = pipe_in_op1_i;
        endcase
    end

    // strided modes take xval as base first, then as the increment
    always_comb begin
        addr_d = addr_q;
        if (pipe_in_valid_i) begin
            unique case (pipe_in_ctrl_i.mode.stride)
                LSU_UNITSTRIDE: addr_d = pipe_in_ctrl_i.first_cycle ?
                                         pipe_in_ctrl_i.xval : addr_q + 32'(VMEM_B);
                LSU_STRIDED:    addr_d = pipe_in_ctrl_i.first_cycle ?
                                         pipe_in_ctrl_i.xval : addr_q + pipe_in_ctrl_i.xval;
                LSU_INDEXED:    addr_d = pipe_in_ctrl_i.xval + index_ext;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // store data and byte enables

    // low vl_part+1 bytes are active unless the beat is empty
    assign unit_vl_mask = pipe_in_ctrl_i.vl_part_0 ? '0 :
                          ({VMEM_B{1'b1}} >> (~pipe_in_ctrl_i.vl_part));
    assign stri_bit     = ~pipe_in_ctrl_i.vl_part_0 &
                          (pipe_in_ctrl_i.mode.masked ? pipe_in_mask_i[0] : 1'b1);
    assign addr_off     = addr_d[OFF_W-1:0];

    always_comb begin
        wdata_d = '0;
        be_d    = '0;
        if (pipe_in_ctrl_i.mode.stride == LSU_UNITSTRIDE) begin
            wdata_d = pipe_in_op2_i;
            be_d    = (pipe_in_ctrl_i.mode.masked ? pipe_in_mask_i : '1) & unit_vl_mask;
        end else begin
            unique case (pipe_in_ctrl_i.mode.eew)
                VSEW_8: begin
                    for (int i = 0; i < VMEM_B; i++) begin
                        wdata_d[i*8 +: 8] = pipe_in_op2_i[7:0];
                    end
                    be_d = VMEM_B'(stri_bit) << addr_off;
                end
                VSEW_16: begin
                    for (int i = 0; i < VMEM_B / 2; i++) begin
                        wdata_d[i*16 +: 16] = pipe_in_op2_i[15:0];
                    end
                    be_d = VMEM_B'({2{stri_bit}}) << {addr_off[OFF_W-1:1], 1'b0};
                end
                default: begin
                    // a 32-bit element fills the whole word
                    wdata_d = pipe_in_op2_i;
                    be_d    = {VMEM_B{stri_bit}};
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // request register

    assign req_accept      = mem_req_valid_o & mem_req_ready_i;
    assign req_ready       = ~req_valid_q | req_accept;
    assign pipe_in_ready_o = req_ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            req_valid_q <= 1'b0;
        end else if (req_ready) begin
            req_valid_q <= pipe_in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_ready & pipe_in_valid_i) begin
            ctrl_q  <= pipe_in_ctrl_i;
            addr_q  <= addr_d;
            wdata_q <= wdata_d;
            be_q    <= be_d;
            mask_q  <= pipe_in_mask_i;
        end
    end

    // hold off while the queue has no room for the request state
    assign mem_req_valid_o = req_valid_q & queue_ready_i;
    assign mem_req_o.id    = ctrl_q.id;
    assign mem_req_o.addr  = {addr_q[31:OFF_W], {OFF_W{1'b0}}};
    assign mem_req_o.we    = ctrl_q.mode.store;
    assign mem_req_o.be    = be_q;
    assign mem_req_o.wdata = wdata_q;
    assign mem_req_o.last  = ctrl_q.last_cycle;

    assign enq_valid_o             = req_accept;
    assign enq_entry_o.off         = addr_q[OFF_W-1:0];
    assign enq_entry_o.mask        = mask_q;
    assign enq_entry_o.first_cycle = ctrl_q.first_cycle;
    assign enq_entry_o.last_cycle  = ctrl_q.last_cycle;
    assign enq_entry_o.id          = ctrl_q.id;
    assign enq_entry_o.mode        = ctrl_q.mode;
    assign enq_entry_o.vl_part     = ctrl_q.vl_part;
    assign enq_entry_o.vl_part_0   = ctrl_q.vl_part_0;
    assign enq_entry_o.res_vaddr   = ctrl_q.res_vaddr;
    assign enq_entry_o.res_store   = ctrl_q.res_store;

    assign pending_load_o  = req_valid_q & ~ctrl_q.mode.store;
    assign pending_store_o = req_valid_q &  ctrl_q.mode.store;

endmodule

//--- hw/vlsu_queue.sv
////////////////////////////////////////////////////////////
// vector LSU request queue
// circular FIFO of in-flight request state
////////////////////////////////////////////////////////////

module vlsu_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  logic                 enq_valid_i,
    input  vlsu_pkg::lsu_entry_t enq_entry_i,
    output logic                 enq_ready_o,
    input  logic                 deq_ready_i,
    output logic                 deq_valid_o,
    output vlsu_pkg::lsu_entry_t deq_entry_o
);

    import vlsu_pkg::*;

    localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);

    lsu_entry_t       mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push, pop;

    assign enq_ready_o = count_q != (PTR_W + 1)'(QUEUE_DEPTH);
    assign deq_valid_o = count_q != '0;
    assign push        = enq_valid_i & enq_ready_o;
    assign pop         = deq_ready_i & deq_valid_o;

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push != pop) begin
                count_q <= push ? count_q + 1'b1 : count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= enq_entry_i;
        end
    end

    assign deq_entry_o = mem_q[rd_ptr_q];

endmodule

//--- hw/vlsu_rdata_stage.sv
////////////////////////////////////////////////////////////
// vector LSU read-data stage
// bus error tracking, completion report and load extraction
////////////////////////////////////////////////////////////

module vlsu_rdata_stage (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,

    input  logic                          mem_result_valid_i,
    input  vlsu_pkg::mem_result_t         mem_result_i,

    input  logic                          deq_valid_i,
    input  vlsu_pkg::lsu_entry_t          deq_entry_i,
    output logic                          deq_ready_o,

    output logic                          pipe_out_valid_o,
    output vlsu_pkg::lsu_ctrl_t           pipe_out_ctrl_o,
    output logic [vlsu_pkg::VMEM_W-1:0]   pipe_out_res_o,
    output logic [vlsu_pkg::VMEM_B-1:0]   pipe_out_mask_o,
    output logic                          pipe_out_pend_clr_o,

    output logic                          trans_cpl_valid_o,
    output vlsu_pkg::trans_cpl_t          trans_cpl_o
);

    import vlsu_pkg::*;

    logic              err_q, err_d;
    logic              rd_valid_q;
    lsu_entry_t        entry_q;
    logic [VMEM_W-1:0] rdata_q;
    logic              exc_q;
    logic [OFF_W-1:0]  off_al;
    logic [VMEM_W-1:0] rdata_shifted;
    logic [VMEM_B-1:0] unit_vl_mask;
    logic              stri_bit;

    // each result retires exactly one queue entry
    assign deq_ready_o = mem_result_valid_i;

    ////////////////////////////////////////////////////////////
    // bus error tracking

    // sticky over the beats of one instruction
    assign err_d = (deq_entry_i.first_cycle ? 1'b0 : err_q) |
                   (mem_result_valid_i & mem_result_i.err);

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            err_q <= 1'b0;
        end else if (mem_result_valid_i) begin
            err_q <= err_d;
        end
    end

    assign trans_cpl_valid_o   = mem_result_valid_i & deq_valid_i & deq_entry_i.last_cycle;
    assign trans_cpl_o.id      = deq_entry_i.id;
    assign trans_cpl_o.exc     = err_d;
    assign trans_cpl_o.exccode = deq_entry_i.mode.store ? EXC_STORE_FAULT : EXC_LOAD_FAULT;

    ////////////////////////////////////////////////////////////
    // read-data register

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= mem_result_valid_i & ~deq_entry_i.mode.store;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_result_valid_i) begin
            rdata_q <= mem_result_i.rdata;
            entry_q <= deq_entry_i;
            exc_q   <= err_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // load output

    // element offset aligned down to the element size
    always_comb begin
        unique case (entry_q.mode.eew)
            VSEW_8:  off_al = entry_q.off;
            VSEW_16: off_al = {entry_q.off[OFF_W-1:1], 1'b0};
            default: off_al = '0;
        endcase
    end

    assign rdata_shifted = rdata_q >> {off_al, 3'b000};
    assign unit_vl_mask  = entry_q.vl_part_0 ? '0 : ({VMEM_B{1'b1}} >> (~entry_q.vl_part));
    assign stri_bit      = ~entry_q.vl_part_0 & (entry_q.mode.masked ? entry_q.mask[0] : 1'b1);

    always_comb begin
        if (entry_q.mode.stride == LSU_UNITSTRIDE) begin
            pipe_out_res_o  = rdata_q;
            pipe_out_mask_o = (entry_q.mode.masked ? entry_q.mask : '1) & unit_vl_mask;
        end else begin
            unique case (entry_q.mode.eew)
                VSEW_8:  pipe_out_res_o = {24'b0, rdata_shifted[7:0]};
                VSEW_16: pipe_out_res_o = {16'b0, rdata_shifted[15:0]};
                default: pipe_out_res_o = rdata_shifted;
            endcase
            pipe_out_mask_o = {VMEM_B{stri_bit}};
        end
    end

    assign pipe_out_valid_o = rd_valid_q;

    always_comb begin
        pipe_out_ctrl_o             = '0;
        pipe_out_ctrl_o.first_cycle = entry_q.first_cycle;
        pipe_out_ctrl_o.last_cycle  = entry_q.last_cycle;
        pipe_out_ctrl_o.id          = entry_q.id;
        pipe_out_ctrl_o.mode        = entry_q.mode;
        pipe_out_ctrl_o.vl_part     = entry_q.vl_part;
        pipe_out_ctrl_o.vl_part_0   = entry_q.vl_part_0;
        pipe_out_ctrl_o.res_vaddr   = entry_q.res_vaddr;
        // no register write once the instruction has faulted
        pipe_out_ctrl_o.res_store   = entry_q.res_store & ~exc_q;
    end

    assign pipe_out_pend_clr_o = entry_q.res_store;

endmodule

//--- hw/vlsu_top.sv
////////////////////////////////////////////////////////////
// vector LSU top level
// request stage, request queue and read-data stage
////////////////////////////////////////////////////////////

module vlsu_top #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                          clk_i,
    input  logic                          async_rst_ni,

    input  logic                          pipe_in_valid_i,
    output logic                          pipe_in_ready_o,
    input  vlsu_pkg::lsu_ctrl_t           pipe_in_ctrl_i,
    input  logic [31:0]                   pipe_in_op1_i,
    input  logic [vlsu_pkg::VMEM_W-1:0]   pipe_in_op2_i,
    input  logic [vlsu_pkg::VMEM_B-1:0]   pipe_in_mask_i,

    output logic                          mem_req_valid_o,
    input  logic                          mem_req_ready_i,
    output vlsu_pkg::mem_req_t            mem_req_o,

    input  logic                          mem_result_valid_i,
    input  vlsu_pkg::mem_result_t         mem_result_i,

    output logic                          pipe_out_valid_o,
    output vlsu_pkg::lsu_ctrl_t           pipe_out_ctrl_o,
    output logic [vlsu_pkg::VMEM_W-1:0]   pipe_out_res_o,
    output logic [vlsu_pkg::VMEM_B-1:0]   pipe_out_mask_o,
    output logic                          pipe_out_pend_clr_o,

    output logic                          trans_cpl_valid_o,
    output vlsu_pkg::trans_cpl_t          trans_cpl_o,

    output logic                          pending_load_o,
    output logic                          pending_store_o
);

    import vlsu_pkg::*;

    logic       queue_ready;
    logic       enq_valid;
    lsu_entry_t enq_entry;
    logic       deq_ready;
    logic       deq_valid;
    lsu_entry_t deq_entry;

    vlsu_req_stage #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) u_req (
        .clk_i           ( clk_i           ),
        .async_rst_ni    ( async_rst_ni    ),
        .pipe_in_valid_i ( pipe_in_valid_i ),
        .pipe_in_ready_o ( pipe_in_ready_o ),
        .pipe_in_ctrl_i  ( pipe_in_ctrl_i  ),
        .pipe_in_op1_i   ( pipe_in_op1_i   ),
        .pipe_in_op2_i   ( pipe_in_op2_i   ),
        .pipe_in_mask_i  ( pipe_in_mask_i  ),
        .mem_req_valid_o ( mem_req_valid_o ),
        .mem_req_ready_i ( mem_req_ready_i ),
        .mem_req_o       ( mem_req_o       ),
        .queue_ready_i   ( queue_ready     ),
        .enq_valid_o     ( enq_valid       ),
        .enq_entry_o     ( enq_entry       ),
        .pending_load_o  ( pending_load_o  ),
        .pending_store_o ( pending_store_o )
    );

    vlsu_queue #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) u_queue (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .enq_valid_i  ( enq_valid    ),
        .enq_entry_i  ( enq_entry    ),
        .enq_ready_o  ( queue_ready  ),
        .deq_ready_i  ( deq_ready    ),
        .deq_valid_o  ( deq_valid    ),
        .deq_entry_o  ( deq_entry    )
    );

    vlsu_rdata_stage u_rdata (
        .clk_i               ( clk_i               ),
        .async_rst_ni        ( async_rst_ni        ),
        .mem_result_valid_i  ( mem_result_valid_i  ),
        .mem_result_i        ( mem_result_i        ),
        .deq_valid_i         ( deq_valid           ),
        .deq_entry_i         ( deq_entry           ),
        .deq_ready_o         ( deq_ready           ),
        .pipe_out_valid_o    ( pipe_out_valid_o    ),
        .pipe_out_ctrl_o     ( pipe_out_ctrl_o     ),
        .pipe_out_res_o      ( pipe_out_res_o      ),
        .pipe_out_mask_o     ( pipe_out_mask_o     ),
        .pipe_out_pend_clr_o ( pipe_out_pend_clr_o ),
        .trans_cpl_valid_o   ( trans_cpl_valid_o   ),
        .trans_cpl_o         ( trans_cpl_o         )
    );

endmodule

//--- tests/vlsu_assert.sv
////////////////////////////////////////////////////////////
// vector LSU protocol checks
// memory request hold, reset quiet outputs, no store write-back
////////////////////////////////////////////////////////////

module vlsu_assert (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  logic                 req_valid_i,
    input  logic                 req_ready_i,
    input  vlsu_pkg::mem_req_t   req_i,
    input  logic                 out_valid_i,
    input  vlsu_pkg::lsu_ctrl_t  out_ctrl_i,
    input  logic                 cpl_valid_i
);

    // a stalled request keeps its valid and its payload
    a_req_hold: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
        else $error("memory request changed while stalled");

    // nothing leaves the LSU while reset is held
    a_reset_quiet: assert property (@(posedge clk_i)
        !async_rst_ni |-> !req_valid_i && !out_valid_i && !cpl_valid_i)
        else $error("output valid high during reset");

    // stores never write back
    a_no_store_out: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_i |-> !out_ctrl_i.mode.store)
        else $error("write-back pulse for a store beat");

endmodule

//--- tests/vlsu_tb.sv
////////////////////////////////////////////////////////////
// vector LSU testbench
// file driven beats, random-latency memory model, result checks
////////////////////////////////////////////////////////////

module vlsu_tb;

    import vlsu_pkg::*;

    localparam int MAX_BEATS = 64;

    logic clk_i = 1'b0;
    logic async_rst_ni;
    logic pipe_in_valid_i, pipe_in_ready_o;
    lsu_ctrl_t pipe_in_ctrl_i;
    logic [31:0] pipe_in_op1_i;
    logic [VMEM_W-1:0] pipe_in_op2_i;
    logic [VMEM_B-1:0] pipe_in_mask_i;
    logic mem_req_valid_o, mem_req_ready_i;
    mem_req_t mem_req_o;
    logic mem_result_valid_i;
    mem_result_t mem_result_i;
    logic pipe_out_valid_o, pipe_out_pend_clr_o;
    lsu_ctrl_t pipe_out_ctrl_o;
    logic [VMEM_W-1:0] pipe_out_res_o;
    logic [VMEM_B-1:0] pipe_out_mask_o;
    logic trans_cpl_valid_o;
    trans_cpl_t trans_cpl_o;
    logic pending_load_o, pending_store_o;

    // per-beat vectors
    lsu_ctrl_t   b_ctrl [MAX_BEATS];
    logic [31:0] b_op1 [MAX_BEATS], b_op2 [MAX_BEATS], b_mask [MAX_BEATS];
    logic [31:0] b_addr [MAX_BEATS], b_be [MAX_BEATS], b_wdata [MAX_BEATS];
    logic [31:0] b_rdata [MAX_BEATS], b_err [MAX_BEATS], b_res [MAX_BEATS];
    logic [31:0] b_omask [MAX_BEATS], b_ors [MAX_BEATS], b_exc [MAX_BEATS], b_code [MAX_BEATS];
    int t_first [MAX_BEATS], t_last [MAX_BEATS];
    int nb = 0, ntests = 0, errors = 0, tests_ok = 0;
    int req_idx = 0, rchk_idx = 0, cyc = 0, last_due = 0, out_beat = 0;
    bit loaded = 0, out_pending = 0;
    int due_q [$], beat_q [$];
    integer seed = 32'hbf1c_f3ff;

    vlsu_top #(.QUEUE_DEPTH(4)) uut (.*);

    bind vlsu_top vlsu_assert u_assert (
        .clk_i(clk_i), .async_rst_ni(async_rst_ni),
        .req_valid_i(mem_req_valid_o), .req_ready_i(mem_req_ready_i), .req_i(mem_req_o),
        .out_valid_i(pipe_out_valid_o), .out_ctrl_i(pipe_out_ctrl_o),
        .cpl_valid_i(trans_cpl_valid_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic compare_field(string what, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic require(bit cond, string msg);
        assert (cond) else begin
            $display("Error at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic load_vectors();
        int fd;
        int n;
        int prev_t;
        string line;
        logic [31:0] v [26];
        prev_t = -1;
        fd = $fopen("tests/vlsu_tests.txt", "r");
        require(fd != 0, "cannot open tests/vlsu_tests.txt");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                            v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17],
                            v[18], v[19], v[20], v[21], v[22], v[23], v[24], v[25]);
                if (n == 26) begin
                    if (int'(v[0]) != prev_t) begin
                        t_first[ntests] = nb;
                        ntests++;
                        prev_t = v[0];
                    end
                    t_last[ntests-1] = nb;
                    b_ctrl[nb] = '0;
                    b_ctrl[nb].first_cycle = v[1][0];
                    b_ctrl[nb].last_cycle  = v[2][0];
                    b_ctrl[nb].id          = v[3][ID_W-1:0];
                    b_ctrl[nb].mode.store  = v[4][0];
                    b_ctrl[nb].mode.masked = v[5][0];
                    b_ctrl[nb].mode.stride = lsu_stride_e'(v[6][1:0]);
                    b_ctrl[nb].mode.eew    = vsew_e'(v[7][1:0]);
                    b_ctrl[nb].vl_part     = v[8][OFF_W-1:0];
                    b_ctrl[nb].vl_part_0   = v[9][0];
                    b_ctrl[nb].xval        = v[10];
                    b_ctrl[nb].res_vaddr   = v[11][4:0];
                    b_ctrl[nb].res_store   = v[12][0];
                    b_op1[nb]   = v[13];
                    b_op2[nb]   = v[14];
                    b_mask[nb]  = v[15];
                    b_addr[nb]  = v[16];
                    b_be[nb]    = v[17];
                    b_wdata[nb] = v[18];
                    b_rdata[nb] = v[19];
                    b_err[nb]   = v[20];
                    b_res[nb]   = v[21];
                    b_omask[nb] = v[22];
                    b_ors[nb]   = v[23];
                    b_exc[nb]   = v[24];
                    b_code[nb]  = v[25];
                    nb++;
                end
            end
        end
        if (fd != 0) $fclose(fd);
    endtask

    task automatic send_beat(int i);
        pipe_in_valid_i <= 1'b1;
        pipe_in_ctrl_i  <= b_ctrl[i];
        pipe_in_op1_i   <= b_op1[i];
        pipe_in_op2_i   <= b_op2[i];
        pipe_in_mask_i  <= b_mask[i][VMEM_B-1:0];
        @(negedge clk_i);
        while (!pipe_in_ready_o) @(negedge clk_i);
        @(posedge clk_i);
    endtask

    ////////////////////////////////////////////////////////////
    // memory model returning results in order after 1 to 3 cycles

    always @(posedge clk_i) begin
        cyc++;
        mem_req_ready_i <= ($random(seed) & 3) != 0;
        if (due_q.size() > 0 && due_q[0] <= cyc) begin
            mem_result_valid_i <= 1'b1;
            mem_result_i <= {b_rdata[beat_q[0]], b_err[beat_q[0]][0]};
            void'(due_q.pop_front());
            void'(beat_q.pop_front());
        end else begin
            mem_result_valid_i <= 1'b0;
        end
    end

    // all outputs are sampled mid-cycle
    always @(negedge clk_i) begin
        int r;
        int due;
        lsu_ctrl_t exp_ctrl;
        if (async_rst_ni) begin
            require(pipe_out_valid_o === out_pending,
                    out_pending ? "load result missing on pipe_out" : "unexpected pipe_out beat");
            if (pipe_out_valid_o && out_pending) begin
                exp_ctrl = b_ctrl[out_beat];
                exp_ctrl.xval = '0;
                exp_ctrl.res_store = b_ors[out_beat][0];
                compare_field("pipe_out_ctrl", pipe_out_ctrl_o, exp_ctrl);
                compare_field("pipe_out_res", pipe_out_res_o, b_res[out_beat]);
                compare_field("pipe_out_mask", pipe_out_mask_o, b_omask[out_beat]);
                compare_field("pipe_out_pend_clr", pipe_out_pend_clr_o,
                              b_ctrl[out_beat].res_store);
            end
            out_pending = 0;
            if (mem_result_valid_i) begin
                r = rchk_idx;
                require(trans_cpl_valid_o === b_ctrl[r].last_cycle,
                        "trans_cpl pulse does not match the last beat");
                if (b_ctrl[r].last_cycle) begin
                    compare_field("trans_cpl.id", trans_cpl_o.id, b_ctrl[r].id);
                    compare_field("trans_cpl.exc", trans_cpl_o.exc, b_exc[r]);
                    compare_field("trans_cpl.exccode", trans_cpl_o.exccode, b_code[r]);
                end
                out_pending = !b_ctrl[r].mode.store;
                out_beat = r;
                rchk_idx++;
            end else begin
                require(!trans_cpl_valid_o, "trans_cpl pulse without a memory result");
            end
            // the beat at the head of the request stream sets the pending kind
            if (mem_req_valid_o && req_idx < nb) begin
                compare_field("pending_load_o", pending_load_o, !b_ctrl[req_idx].mode.store);
                compare_field("pending_store_o", pending_store_o, b_ctrl[req_idx].mode.store);
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                r = req_idx;
                require(r < nb, "extra memory request beyond the last beat");
                if (r < nb) begin
                    compare_field("req.addr", mem_req_o.addr, b_addr[r]);
                    compare_field("req.be", mem_req_o.be, b_be[r]);
                    compare_field("req.wdata", mem_req_o.wdata, b_wdata[r]);
                    compare_field("req.we", mem_req_o.we, b_ctrl[r].mode.store);
                    compare_field("req.id", mem_req_o.id, b_ctrl[r].id);
                    compare_field("req.last", mem_req_o.last, b_ctrl[r].last_cycle);
                    due = cyc + 1 + 1 + (($random(seed) & 32'h7fff_ffff) % 3);
                    if (due <= last_due) due = last_due + 1;
                    last_due = due;
                    due_q.push_back(due);
                    beat_q.push_back(r);
                    req_idx++;
                end
            end
        end
    end

    initial begin
        wait (loaded);
        #((nb * 20 + 200) * 10);
        $display("Error: watchdog expired before all beats completed");
        $display("test failed");
        $finish;
    end

    initial begin
        int err_before;
        async_rst_ni = 1'b0;
        pipe_in_valid_i = 1'b0;
        pipe_in_ctrl_i = '0;
        pipe_in_op1_i = '0;
        pipe_in_op2_i = '0;
        pipe_in_mask_i = '0;
        mem_req_ready_i = 1'b0;
        mem_result_valid_i = 1'b0;
        mem_result_i = '0;
        load_vectors();
        loaded = 1;
        repeat (16) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        @(posedge clk_i);
        for (int k = 0; k < ntests; k++) begin
            err_before = errors;
            for (int i = t_first[k]; i <= t_last[k]; i++) begin
                send_beat(i);
            end
            pipe_in_valid_i <= 1'b0;
            wait (rchk_idx > t_last[k]);
            repeat (2) @(posedge clk_i);
            if (errors == err_before) begin
                tests_ok++;
                $display("test %0d: %0d beats ok", k + 1, t_last[k] - t_first[k] + 1);
            end else begin
                $display("test %0d: %0d errors", k + 1, errors - err_before);
            end
        end
        require(nb > 0, "no vectors were read");
        require(req_idx == nb, "request count differs from beat count");
        $display("%0d tests, %0d ok, %0d failing, %0d errors",
                 ntests, tests_ok, ntests - tests_ok, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tests/vlsu_tests.txt
# t first last id store masked stride eew vl_part vl_part_0 xval res_vaddr res_store op1 op2 mask
#   exp_addr exp_be exp_wdata | rdata err | exp_res exp_mask exp_res_store exp_exc exp_code
1 1 0 1 1 1 0 2 3 0 1002 0 0 0 aabbccdd f 1000 f aabbccdd 0 0 0 0 0 0 7
1 0 0 1 1 1 0 2 3 0 1002 0 0 0 11223344 5 1004 5 11223344 0 0 0 0 0 0 7
1 0 1 1 1 1 0 2 1 0 1002 0 0 0 55667788 f 1008 3 55667788 0 0 0 0 0 0 7
2 1 0 2 1 0 1 0 3 0 3 0 0 0 a5 f 0 8 a5a5a5a5 0 0 0 0 0 0 7
2 0 1 2 1 0 1 0 3 0 3 0 0 0 3c f 4 4 3c3c3c3c 0 0 0 0 0 0 7
3 1 0 3 1 1 1 1 3 0 22 0 0 0 1234 1 20 c 12341234 0 0 0 0 0 0 7
3 0 1 3 1 1 1 1 3 0 22 0 0 0 beef 2 44 0 beefbeef 0 0 0 0 0 0 7
4 1 0 4 1 0 1 2 3 0 100 0 0 0 deadbeef f 100 f deadbeef 0 0 0 0 0 0 7
4 0 1 4 1 0 1 2 3 1 100 0 0 0 01020304 f 200 0 01020304 0 0 0 0 0 0 7
5 1 0 5 0 0 2 0 3 0 2000 a 1 105 0 f 2004 2 0 44332211 0 22 f 1 0 5
5 0 0 5 0 0 2 0 3 0 2000 a 1 e 0 f 200c 4 0 88776655 0 77 f 1 0 5
5 0 1 5 0 0 2 0 3 0 2000 a 1 ff03 0 f 2000 8 0 a1b2c3d4 0 a1 f 1 0 5
6 1 0 6 0 0 2 1 3 0 3000 b 1 12346 0 f 5344 c 0 cafe1234 0 cafe f 1 0 5
6 0 1 6 0 0 2 1 3 0 3000 b 1 10 0 f 3010 3 0 5555abcd 0 abcd f 1 0 5
7 1 0 7 0 1 0 2 3 0 4000 3 1 0 0 6 4000 6 0 11112222 0 11112222 6 1 0 5
7 0 0 7 0 1 0 2 3 0 4000 3 1 0 0 f 4004 f 0 33334444 0 33334444 f 1 0 5
7 0 1 7 0 1 0 2 2 0 4000 3 1 0 0 9 4008 1 0 55556666 0 55556666 1 1 0 5
8 1 0 0 0 0 0 2 3 0 5000 4 1 0 0 0 5000 f 0 a0a0a0a0 0 a0a0a0a0 f 1 1 5
8 0 0 0 0 0 0 2 3 0 5000 4 1 0 0 0 5004 f 0 b0b0b0b0 1 b0b0b0b0 f 0 1 5
8 0 1 0 0 0 0 2 3 0 5000 4 1 0 0 0 5008 f 0 c0c0c0c0 0 c0c0c0c0 f 0 1 5
9 1 0 1 1 0 0 2 3 0 6000 0 0 0 1 0 6000 f 1 0 0 0 0 0 1 7
9 0 0 1 1 0 0 2 3 0 6000 0 0 0 2 0 6004 f 2 0 1 0 0 0 1 7
9 0 1 1 1 0 0 2 3 0 6000 0 0 0 3 0 6008 f 3 0 0 0 0 0 1 7

//--- verilog.f
hw/vlsu_pkg.sv
hw/vlsu_req_stage.sv
hw/vlsu_queue.sv
hw/vlsu_rdata_stage.sv
hw/vlsu_top.sv
tests/vlsu_assert.sv
tests/vlsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the vector LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module vlsu_tb -f verilog.f -o vlsu_sim

./obj_dir/vlsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
    exit 0
else
    exit 1
fi
